// ==== common/vq_pkg.sv ====
`default_nettype none

package vq_pkg;

    // Default sizes, each one overridable from vq_top
    localparam int VQ_DEFAULT_ADDR_WIDTH = 32;

    // Line size in bytes
    localparam int VQ_DEFAULT_LINE_SIZE  = 32;

    // Number of victim queue entries
    localparam int VQ_DEFAULT_DEPTH      = 4;

    // State of one queue entry
    // INVALID means the slot is free, VALID means it holds a dirty line
    typedef enum logic {
        INVALID = 1'b0,
        VALID   = 1'b1
    } vq_state_e;

endpackage

`default_nettype wire

// ==== victim_queue/vq_entry.sv ====
`timescale 1ns/1ns
`default_nettype none

module vq_entry import vq_pkg::*; #(
    parameter int OPTN_ADDR_WIDTH   = VQ_DEFAULT_ADDR_WIDTH,
    parameter int OPTN_DC_LINE_SIZE = VQ_DEFAULT_LINE_SIZE,

    localparam int LINE_WIDTH       = OPTN_DC_LINE_SIZE * 8,
    localparam int OFFSET_WIDTH     = $clog2(OPTN_DC_LINE_SIZE)
)(
    input  logic                                  clk,
    input  logic                                  i_arst_n,

    // Allocation of a victim line into this slot
    input  logic                                  i_alloc_en,
    input  logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] i_alloc_addr,
    input  logic [LINE_WIDTH-1:0]                 i_alloc_data,

    // Writeback granted, slot is released
    input  logic                                  i_retire,

    input  logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] i_lookup_addr,

    output logic                                  o_valid,
    output logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] o_addr,
    output logic [LINE_WIDTH-1:0]                 o_data,
    output logic                                  o_lookup_hit
);

    vq_state_e                             state_r;
    vq_state_e                             state_next;
    logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] addr_r;
    logic [LINE_WIDTH-1:0]                 data_r;

    // A retire and a new allocation in one cycle keep the slot occupied
    always_comb begin
        state_next = state_r;
        case (state_r)
            INVALID: begin
                if (i_alloc_en) begin
                    state_next = VALID;
                end
            end
            VALID: begin
                if (i_retire && !i_alloc_en) begin
                    state_next = INVALID;
                end
            end
            default: state_next = INVALID;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_r <= INVALID;
        end else begin
            state_r <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            addr_r <= i_alloc_addr;
            data_r <= i_alloc_data;
        end
    end

    assign o_valid      = (state_r == VALID);
    assign o_addr       = addr_r;
    assign o_data       = data_r;
    assign o_lookup_hit = o_valid && (addr_r == i_lookup_addr);

endmodule

`default_nettype wire

// ==== victim_queue/vq_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module vq_ctrl import vq_pkg::*; #(
    parameter int OPTN_VQ_DEPTH = VQ_DEFAULT_DEPTH,

    localparam int IDX_WIDTH    = (OPTN_VQ_DEPTH > 1) ? $clog2(OPTN_VQ_DEPTH) : 1,
    localparam int CNT_WIDTH    = $clog2(OPTN_VQ_DEPTH + 1)
)(
    input  logic                     clk,
    input  logic                     i_arst_n,

    input  logic                     i_alloc_en,
    input  logic                     i_ccu_grant,

    // One-hot strobes towards the entries
    output logic [OPTN_VQ_DEPTH-1:0] o_alloc_sel,
    output logic [OPTN_VQ_DEPTH-1:0] o_grant_sel,

    output logic [IDX_WIDTH-1:0]     o_head_idx,
    output logic                     o_full,
    output logic                     o_ccu_req
);

    localparam logic [IDX_WIDTH-1:0] LAST_IDX  = IDX_WIDTH'(OPTN_VQ_DEPTH - 1);
    localparam logic [CNT_WIDTH-1:0] DEPTH_CNT = CNT_WIDTH'(OPTN_VQ_DEPTH);

    logic [IDX_WIDTH-1:0] head_r;
    logic [IDX_WIDTH-1:0] tail_r;
    logic [CNT_WIDTH-1:0] count_r;
    logic                 alloc_ok;
    logic                 grant_ok;

    assign o_ccu_req = (count_r != '0);
    assign o_full    = (count_r == DEPTH_CNT);

    // Grant only counts while something is waiting
    assign grant_ok  = i_ccu_grant && o_ccu_req;

    // When full, the same-cycle grant frees the head slot, which is also the tail
    assign alloc_ok  = i_alloc_en && (!o_full || grant_ok);

    always_comb begin
        o_alloc_sel = '0;
        o_grant_sel = '0;
        if (alloc_ok) begin
            o_alloc_sel[tail_r] = 1'b1;
        end
        if (grant_ok) begin
            o_grant_sel[head_r] = 1'b1;
        end
    end

    assign o_head_idx = head_r;

    // Pointers wrap at the queue depth, which need not be a power of two
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            tail_r <= '0;
        end else if (alloc_ok) begin
            if (tail_r == LAST_IDX) begin
                tail_r <= '0;
            end else begin
                tail_r <= tail_r + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            head_r <= '0;
        end else if (grant_ok) begin
            if (head_r == LAST_IDX) begin
                head_r <= '0;
            end else begin
                head_r <= head_r + 1'b1;
            end
        end
    end

    // Occupancy, unchanged when one line enters and one leaves
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            count_r <= '0;
        end else begin
            case ({alloc_ok, grant_ok})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== victim_queue/vq_lookup.sv ====
`timescale 1ns/1ns
`default_nettype none

module vq_lookup import vq_pkg::*; #(
    parameter int OPTN_DC_LINE_SIZE = VQ_DEFAULT_LINE_SIZE,
    parameter int OPTN_VQ_DEPTH     = VQ_DEFAULT_DEPTH,

    localparam int LINE_WIDTH       = OPTN_DC_LINE_SIZE * 8
)(
    // Per-entry hit flags and stored lines
    input  logic [OPTN_VQ_DEPTH-1:0]                 i_hit_vec,
    input  logic [OPTN_VQ_DEPTH-1:0][LINE_WIDTH-1:0] i_data_vec,

    output logic                                     o_lookup_hit,
    output logic [LINE_WIDTH-1:0]                    o_lookup_data
);

    assign o_lookup_hit = |i_hit_vec;

    // AND-OR mux. The cache never queues one line address twice,
    // so at most one term is nonzero
    always_comb begin
        o_lookup_data = '0;
        for (int i = 0; i < OPTN_VQ_DEPTH; i++) begin
            o_lookup_data = o_lookup_data | (i_data_vec[i] & {LINE_WIDTH{i_hit_vec[i]}});
        end
    end

endmodule

`default_nettype wire

// ==== hw/vq_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module vq_top import vq_pkg::*; #(
    parameter int OPTN_ADDR_WIDTH   = VQ_DEFAULT_ADDR_WIDTH,
    parameter int OPTN_DC_LINE_SIZE = VQ_DEFAULT_LINE_SIZE,
    parameter int OPTN_VQ_DEPTH     = VQ_DEFAULT_DEPTH,

    localparam int LINE_WIDTH       = OPTN_DC_LINE_SIZE * 8,
    localparam int OFFSET_WIDTH     = $clog2(OPTN_DC_LINE_SIZE),
    localparam int IDX_WIDTH        = (OPTN_VQ_DEPTH > 1) ? $clog2(OPTN_VQ_DEPTH) : 1
)(
    input  logic                                  clk,
    input  logic                                  i_arst_n,

    // Eviction from the data cache
    input  logic                                  i_alloc_en,
    input  logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] i_alloc_addr,
    input  logic [LINE_WIDTH-1:0]                 i_alloc_data,
    output logic                                  o_full,

    // LSU lookup, answered in the same cycle
    input  logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] i_lookup_addr,
    output logic                                  o_lookup_hit,
    output logic [LINE_WIDTH-1:0]                 o_lookup_data,

    // Writeback to the CCU
    input  logic                                  i_ccu_grant,
    output logic                                  o_ccu_req,
    output logic [OPTN_ADDR_WIDTH-1:OFFSET_WIDTH] o_ccu_addr,
    output logic [LINE_WIDTH-1:0]                 o_ccu_data
);

    logic [OPTN_VQ_DEPTH-1:0]                                    w_alloc_sel;
    logic [OPTN_VQ_DEPTH-1:0]                                    w_grant_sel;
    logic [IDX_WIDTH-1:0]                                        w_head_idx;
    logic [OPTN_VQ_DEPTH-1:0]                                    w_valid_vec;
    logic [OPTN_VQ_DEPTH-1:0]                                    w_hit_vec;
    logic [OPTN_VQ_DEPTH-1:0][OPTN_ADDR_WIDTH-1:OFFSET_WIDTH]   w_addr_vec;
    logic [OPTN_VQ_DEPTH-1:0][LINE_WIDTH-1:0]                    w_data_vec;

    vq_ctrl #(
        .OPTN_VQ_DEPTH (OPTN_VQ_DEPTH)
    ) u_ctrl (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_alloc_en  (i_alloc_en),
        .i_ccu_grant (i_ccu_grant),
        .o_alloc_sel (w_alloc_sel),
        .o_grant_sel (w_grant_sel),
        .o_head_idx  (w_head_idx),
        .o_full      (o_full),
        .o_ccu_req   (o_ccu_req)
    );

    for (genvar i = 0; i < OPTN_VQ_DEPTH; i++) begin : gen_entry
        vq_entry #(
            .OPTN_ADDR_WIDTH   (OPTN_ADDR_WIDTH),
            .OPTN_DC_LINE_SIZE (OPTN_DC_LINE_SIZE)
        ) u_entry (
            .clk           (clk),
            .i_arst_n      (i_arst_n),
            .i_alloc_en    (w_alloc_sel[i]),
            .i_alloc_addr  (i_alloc_addr),
            .i_alloc_data  (i_alloc_data),
            .i_retire      (w_grant_sel[i]),
            .i_lookup_addr (i_lookup_addr),
            .o_valid       (w_valid_vec[i]),
            .o_addr        (w_addr_vec[i]),
            .o_data        (w_data_vec[i]),
            .o_lookup_hit  (w_hit_vec[i])
        );
    end

    vq_lookup #(
        .OPTN_DC_LINE_SIZE (OPTN_DC_LINE_SIZE),
        .OPTN_VQ_DEPTH     (OPTN_VQ_DEPTH)
    ) u_lookup (
        .i_hit_vec     (w_hit_vec),
        .i_data_vec    (w_data_vec),
        .o_lookup_hit  (o_lookup_hit),
        .o_lookup_data (o_lookup_data)
    );

    // Oldest line goes out first
    assign o_ccu_addr = w_addr_vec[w_head_idx];
    assign o_ccu_data = w_data_vec[w_head_idx];

endmodule

`default_nettype wire

// ==== verif/vq_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module vq_assertions import vq_pkg::*; #(
    parameter int OPTN_VQ_DEPTH = VQ_DEFAULT_DEPTH
)(
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  logic                     i_ccu_grant,
    input  logic                     i_ccu_req,
    input  logic                     i_full,
    input  logic [OPTN_VQ_DEPTH-1:0] i_alloc_sel,
    input  logic [OPTN_VQ_DEPTH-1:0] i_grant_sel,
    input  logic [OPTN_VQ_DEPTH-1:0] i_hit_vec,
    input  logic [OPTN_VQ_DEPTH-1:0] i_valid_vec
);

    int valid_count;

    // Occupied slots, counted from the entry states
    always_comb begin
        valid_count = 0;
        for (int i = 0; i < OPTN_VQ_DEPTH; i++) begin
            if (vq_state_e'(i_valid_vec[i]) == VALID) begin
                valid_count++;
            end
        end
    end

    // The retired slot must be one that holds a waiting line
    a_grant_needs_req: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_grant_sel != '0) |-> (i_ccu_req && $onehot(i_grant_sel & i_valid_vec)))
        else $error("retire strobe without a pending request");

    a_single_hit: assert property (@(posedge clk) disable iff (!i_arst_n)
        $onehot0(i_hit_vec))
        else $error("more than one entry hits the lookup address");

    a_full_means_depth: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_full |-> (valid_count == OPTN_VQ_DEPTH))
        else $error("full flag set with free slots");

    // When full, a new line may only land in the slot retired at the same edge
    a_no_alloc_when_full: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_full && (i_alloc_sel != '0)) |-> (i_alloc_sel == i_grant_sel))
        else $error("allocation accepted while full without a grant");

endmodule

bind vq_top vq_assertions #(
    .OPTN_VQ_DEPTH (OPTN_VQ_DEPTH)
) u_assertions (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_ccu_grant (i_ccu_grant),
    .i_ccu_req   (o_ccu_req),
    .i_full      (o_full),
    .i_alloc_sel (w_alloc_sel),
    .i_grant_sel (w_grant_sel),
    .i_hit_vec   (w_hit_vec),
    .i_valid_vec (w_valid_vec)
);

`default_nettype wire

// ==== verif/vq_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module vq_tb import vq_pkg::*; ();

    localparam int ADDR_WIDTH   = VQ_DEFAULT_ADDR_WIDTH;
    localparam int LINE_SIZE    = VQ_DEFAULT_LINE_SIZE;
    localparam int DEPTH        = VQ_DEFAULT_DEPTH;
    localparam int LINE_WIDTH   = LINE_SIZE * 8;
    localparam int OFFSET_WIDTH = $clog2(LINE_SIZE);
    localparam int WAIT_LIMIT   = DEPTH * 4;
    localparam int RANDOM_CYCLES = 2000;

    typedef logic [ADDR_WIDTH-OFFSET_WIDTH-1:0] line_addr_t;
    typedef logic [LINE_WIDTH-1:0]              line_data_t;

    logic       clk;
    logic       i_arst_n;
    logic       i_alloc_en;
    line_addr_t i_alloc_addr;
    line_data_t i_alloc_data;
    line_addr_t i_lookup_addr;
    logic       i_ccu_grant;
    logic       o_full;
    logic       o_lookup_hit;
    line_data_t o_lookup_data;
    logic       o_ccu_req;
    line_addr_t o_ccu_addr;
    line_data_t o_ccu_data;

    // Reference queue, head at index 0
    line_addr_t model_addr[$];
    line_data_t model_data[$];
    logic       model_grant_ok;
    logic       model_alloc_ok;

    integer              seed = 32'h6356;
    string               test_name = "init";
    int                  check_count = 0;
    int                  mismatch_count = 0;
    int                  timeout_count = 0;
    line_addr_t          last_alloc_addr;
    logic                exp_req;
    logic                exp_full;
    logic [LINE_WIDTH:0] exp_lookup;

    vq_top #(
        .OPTN_ADDR_WIDTH   (ADDR_WIDTH),
        .OPTN_DC_LINE_SIZE (LINE_SIZE),
        .OPTN_VQ_DEPTH     (DEPTH)
    ) i_dut (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_alloc_en    (i_alloc_en),
        .i_alloc_addr  (i_alloc_addr),
        .i_alloc_data  (i_alloc_data),
        .o_full        (o_full),
        .i_lookup_addr (i_lookup_addr),
        .o_lookup_hit  (o_lookup_hit),
        .o_lookup_data (o_lookup_data),
        .i_ccu_grant   (i_ccu_grant),
        .o_ccu_req     (o_ccu_req),
        .o_ccu_addr    (o_ccu_addr),
        .o_ccu_data    (o_ccu_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic line_addr_t random_line_addr();
        return line_addr_t'($random(seed));
    endfunction

    function automatic line_data_t random_line_data();
        line_data_t d;
        for (int k = 0; k < LINE_WIDTH / 32; k++) begin
            d[k*32 +: 32] = $random(seed);
        end
        return d;
    endfunction

    // Expected lookup answer, hit flag on top of the line data
    function automatic logic [LINE_WIDTH:0] lookup_ref(input line_addr_t addr);
        logic [LINE_WIDTH:0] res;
        res = '0;
        foreach (model_addr[k]) begin
            if (model_addr[k] == addr) begin
                res = {1'b1, model_data[k]};
            end
        end
        return res;
    endfunction

    // The cache never evicts a line that is already queued
    function automatic line_addr_t new_unique_addr();
        line_addr_t          addr;
        logic [LINE_WIDTH:0] res;
        addr = random_line_addr();
        res  = lookup_ref(addr);
        while (res[LINE_WIDTH]) begin
            addr = random_line_addr();
            res  = lookup_ref(addr);
        end
        return addr;
    endfunction

    function automatic line_addr_t pick_lookup(input logic from_queue);
        int idx;
        if (from_queue && (model_addr.size() != 0)) begin
            idx = $unsigned($random(seed)) % model_addr.size();
            return model_addr[idx];
        end
        return random_line_addr();
    endfunction

    // Reference update with the accept rules of the queue
    always @(posedge clk) begin
        if (!i_arst_n) begin
            model_addr.delete();
            model_data.delete();
        end else begin
            model_grant_ok = i_ccu_grant && (model_addr.size() != 0);
            model_alloc_ok = i_alloc_en && ((model_addr.size() < DEPTH) || model_grant_ok);
            if (model_grant_ok) begin
                void'(model_addr.pop_front());
                void'(model_data.pop_front());
            end
            if (model_alloc_ok) begin
                model_addr.push_back(i_alloc_addr);
                model_data.push_back(i_alloc_data);
            end
        end
    end

    // Outputs are settled a nanosecond after the falling edge
    always @(negedge clk) begin
        #1;
        exp_req    = (model_addr.size() != 0);
        exp_full   = (model_addr.size() == DEPTH);
        exp_lookup = lookup_ref(i_lookup_addr);
        check_count++;
        if (o_ccu_req !== exp_req) begin
            mismatch_count++;
            $display("mismatch %s o_ccu_req expected %0b actual %0b", test_name, exp_req, o_ccu_req);
        end
        if (o_full !== exp_full) begin
            mismatch_count++;
            $display("mismatch %s o_full expected %0b actual %0b", test_name, exp_full, o_full);
        end
        if (o_lookup_hit !== exp_lookup[LINE_WIDTH]) begin
            mismatch_count++;
            $display("mismatch %s o_lookup_hit expected %0b actual %0b",
                     test_name, exp_lookup[LINE_WIDTH], o_lookup_hit);
        end
        if (exp_lookup[LINE_WIDTH] && (o_lookup_data !== exp_lookup[LINE_WIDTH-1:0])) begin
            mismatch_count++;
            $display("mismatch %s o_lookup_data expected %h actual %h",
                     test_name, exp_lookup[LINE_WIDTH-1:0], o_lookup_data);
        end
        if (exp_req && (o_ccu_addr !== model_addr[0])) begin
            mismatch_count++;
            $display("mismatch %s o_ccu_addr expected %h actual %h",
                     test_name, model_addr[0], o_ccu_addr);
        end
        if (exp_req && (o_ccu_data !== model_data[0])) begin
            mismatch_count++;
            $display("mismatch %s o_ccu_data expected %h actual %h",
                     test_name, model_data[0], o_ccu_data);
        end
    end

    // Called at a falling edge, returns at the next one
    task automatic drive_cycle(input logic alloc, input logic grant, input line_addr_t lkp);
        i_alloc_en    = alloc;
        i_ccu_grant   = grant;
        i_lookup_addr = lkp;
        if (alloc) begin
            i_alloc_addr    = new_unique_addr();
            i_alloc_data    = random_line_data();
            last_alloc_addr = i_alloc_addr;
        end
        @(negedge clk);
        i_alloc_en  = 1'b0;
        i_ccu_grant = 1'b0;
    endtask

    task automatic fill_queue();
        int waited;
        waited = 0;
        while (!o_full && (waited < WAIT_LIMIT)) begin
            drive_cycle(1'b1, 1'b0, pick_lookup(1'b1));
            waited++;
        end
        if (!o_full) begin
            timeout_count++;
            $display("timeout in %s: queue not full after %0d allocations", test_name, waited);
        end
    endtask

    // Grants with an idle cycle between them
    task automatic drain_queue();
        int waited;
        waited = 0;
        while (o_ccu_req && (waited < WAIT_LIMIT)) begin
            drive_cycle(1'b0, 1'b1, pick_lookup(1'b1));
            drive_cycle(1'b0, 1'b0, pick_lookup(1'b1));
            waited++;
        end
        if (o_ccu_req) begin
            timeout_count++;
            $display("timeout in %s: queue still requesting after %0d grants", test_name, waited);
        end
    endtask

    initial begin
        line_addr_t first_addr;
        line_addr_t dropped_addr;
        logic [31:0] r;

        i_arst_n      = 1'b0;
        i_alloc_en    = 1'b0;
        i_alloc_addr  = '0;
        i_alloc_data  = '0;
        i_lookup_addr = '0;
        i_ccu_grant   = 1'b0;

        test_name = "reset";
        repeat (3) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;
        repeat (4) drive_cycle(1'b0, 1'b0, random_line_addr());

        test_name = "drain_order";
        repeat (3) drive_cycle(1'b1, 1'b0, pick_lookup(1'b1));
        drain_queue();

        test_name = "lookup";
        drive_cycle(1'b1, 1'b0, random_line_addr());
        first_addr = last_alloc_addr;
        drive_cycle(1'b1, 1'b0, first_addr);
        drive_cycle(1'b0, 1'b0, last_alloc_addr);
        drive_cycle(1'b0, 1'b1, first_addr);
        drive_cycle(1'b0, 1'b0, first_addr);
        drive_cycle(1'b0, 1'b0, random_line_addr());
        drain_queue();

        test_name = "full";
        fill_queue();
        drive_cycle(1'b1, 1'b0, pick_lookup(1'b1));
        dropped_addr = last_alloc_addr;
        drive_cycle(1'b1, 1'b0, dropped_addr);
        drive_cycle(1'b0, 1'b0, dropped_addr);
        drain_queue();

        test_name = "grant_empty";
        drive_cycle(1'b0, 1'b1, random_line_addr());
        drive_cycle(1'b0, 1'b1, random_line_addr());

        test_name = "full_swap";
        fill_queue();
        drive_cycle(1'b1, 1'b1, pick_lookup(1'b1));
        drive_cycle(1'b1, 1'b1, last_alloc_addr);
        drive_cycle(1'b0, 1'b0, pick_lookup(1'b1));
        drain_queue();

        test_name = "random";
        repeat (RANDOM_CYCLES) begin
            r = $random(seed);
            drive_cycle(r[0], r[1], pick_lookup(r[2]));
        end
        drain_queue();

        repeat (2) @(negedge clk);
        $display("checks: %0d, mismatches: %0d, timeouts: %0d",
                 check_count, mismatch_count, timeout_count);
        if ((mismatch_count == 0) && (timeout_count == 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/vq_pkg.sv
victim_queue/vq_entry.sv
victim_queue/vq_ctrl.sv
victim_queue/vq_lookup.sv
hw/vq_top.sv
verif/vq_assertions.sv
verif/vq_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the victim queue testbench with Verilator and run it

set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert \
    --timescale 1ns/1ns \
    --top-module vq_tb \
    -Mdir obj_dir \
    -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

if [ ! -x obj_dir/Vvq_tb ]; then
    echo "simulation binary obj_dir/Vvq_tb is missing"
    exit 1
fi

output="$(./obj_dir/Vvq_tb 2>&1)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# The run passes only if the testbench printed its pass line
if echo "$output" | grep -qxF ">>> PASS"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
